// ==== dv/tb_poly_buf.sv ====
// testbench for the coefficient buffer with clock, LCG stimulus, reference model and watchdog
`include "poly_buf_defs.svh"

module tb_poly_buf;

    localparam int CLK_PERIOD     = 40;
    localparam int RESET_CYCLES   = 10;
    localparam int N_XFERS        = 6;      // loads plus stores in the sequence
    localparam int TIMEOUT        = N_XFERS * 1100 * CLK_PERIOD;
    localparam int WORDS_PER_COEF = `COEF_W / 32;

    // stray requests inside a transfer, by cycle
    localparam int LOAD_STRAY_STOR = 200;
    localparam int LOAD_STRAY_LOAD = 700;
    localparam int STOR_STRAY_LOAD = 300;
    localparam int STOR_STRAY_STOR = 800;

    logic                   clk;
    logic                   rst_n;
    logic                   load_req;
    logic                   stor_req;
    poly_buf_pkg::coef_t    d_in;
    logic                   load_busy;
    logic                   load_done;
    logic                   stor_done;
    poly_buf_pkg::coef_t    d_out;
    logic                   d_out_valid;

    logic [31:0]            lcg_state;

    //////////////////////////////
    // reference model state
    //////////////////////////////
    poly_buf_pkg::coef_t    model_mem [`N_SETS][`N_COEF];
    poly_buf_pkg::set_sel_t model_load_set;     // set the last load filled
    poly_buf_pkg::set_sel_t model_stor_set;     // set the last store read

    //////////////////////////////
    // DUT and clock
    //////////////////////////////
    poly_buf_top UUT (
        .clk           (clk),
        .rst_n         (rst_n),
        .load_i        (load_req),
        .stor_i        (stor_req),
        .d_in_i        (d_in),
        .load_busy_o   (load_busy),
        .load_done_o   (load_done),
        .stor_done_o   (stor_done),
        .d_out_o       (d_out),
        .d_out_valid_o (d_out_valid)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    //////////////////////////////
    // random numbers
    //////////////////////////////
    function automatic logic [31:0] lcg_step(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    // one coefficient from eight LCG words
    task automatic random_coef(output poly_buf_pkg::coef_t word);
        for (int w = 0; w < WORDS_PER_COEF; w++) begin
            lcg_state = lcg_step(lcg_state);
            word = {word[`COEF_W-33:0], lcg_state};
        end
    endtask

    //////////////////////////////
    // checks
    //////////////////////////////
    task automatic abort_run();
        $display("TEST FAILED");
        $fatal(1);
    endtask

    task automatic check_coef(input string name, input poly_buf_pkg::coef_t exp_val,
                              input poly_buf_pkg::coef_t act_val);
        if (act_val !== exp_val) begin
            $display("[FAIL] %0t %s expected %h actual %h", $time, name, exp_val, act_val);
            abort_run();
        end
    endtask

    task automatic check_bit(input string name, input logic exp_val, input logic act_val);
        if (act_val !== exp_val) begin
            $display("[FAIL] %0t %s expected %b actual %b", $time, name, exp_val, act_val);
            abort_run();
        end
    endtask

    // all control outputs low between transfers
    task automatic expect_quiet();
        check_bit("load_busy_o", 1'b0, load_busy);
        check_bit("load_done_o", 1'b0, load_done);
        check_bit("stor_done_o", 1'b0, stor_done);
        check_bit("d_out_valid_o", 1'b0, d_out_valid);
    endtask

    //////////////////////////////
    // stimulus
    //////////////////////////////
    task automatic idle_gap();
        int len;
        lcg_state = lcg_step(lcg_state);
        len = int'(lcg_state[18:16]) + 1;   // 1 to 8 idle cycles
        repeat (len) begin
            @(negedge clk);
            expect_quiet();
            load_req = 1'b0;
            stor_req = 1'b0;
            random_coef(d_in);                // garbage that must not be written
        end
    endtask

    task automatic run_load(input logic with_stor);
        poly_buf_pkg::coef_t     word;
        poly_buf_pkg::coef_idx_t idx;
        @(negedge clk);
        expect_quiet();
        load_req = 1'b1;
        stor_req = with_stor;                 // load wins when both are high
        random_coef(d_in);
        model_load_set = ~model_load_set;
        for (int n = 0; n < `N_COEF; n++) begin
            @(negedge clk);                   // busy cycle n
            idx = poly_buf_pkg::coef_idx_t'(n);
            check_bit("load_busy_o", 1'b1, load_busy);
            check_bit("load_done_o", 1'b0, load_done);
            check_bit("d_out_valid_o", 1'b0, d_out_valid);
            load_req = (n == LOAD_STRAY_LOAD);
            stor_req = (n == LOAD_STRAY_STOR);
            random_coef(word);
            d_in = word;
            model_mem[model_load_set][idx] = word;
        end
        @(negedge clk);
        check_bit("load_busy_o", 1'b0, load_busy);
        check_bit("load_done_o", 1'b1, load_done);
        load_req = 1'b0;
        stor_req = 1'b0;
        random_coef(d_in);
    endtask

    task automatic run_store();
        poly_buf_pkg::coef_idx_t idx;
        @(negedge clk);
        expect_quiet();
        stor_req = 1'b1;
        load_req = 1'b0;
        random_coef(d_in);
        model_stor_set = ~model_stor_set;
        // store cycle 0, first read issued
        @(negedge clk);
        stor_req = 1'b0;
        check_bit("d_out_valid_o", 1'b0, d_out_valid);
        check_bit("stor_done_o", 1'b0, stor_done);
        check_bit("load_busy_o", 1'b0, load_busy);
        for (int n = 0; n < `N_COEF; n++) begin
            @(negedge clk);                   // word n valid
            idx = poly_buf_pkg::coef_idx_t'(n);
            check_bit("d_out_valid_o", 1'b1, d_out_valid);
            check_coef("d_out_o", model_mem[model_stor_set][idx], d_out);
            check_bit("stor_done_o", n == `N_COEF - 1, stor_done);
            check_bit("load_busy_o", 1'b0, load_busy);
            load_req = (n == STOR_STRAY_LOAD);
            stor_req = (n == STOR_STRAY_STOR);
            random_coef(d_in);
        end
        @(negedge clk);
        check_bit("d_out_valid_o", 1'b0, d_out_valid);
        check_bit("stor_done_o", 1'b0, stor_done);
        load_req = 1'b0;
        stor_req = 1'b0;
    endtask

    //////////////////////////////
    // watchdog
    //////////////////////////////
    initial begin
        #(TIMEOUT);
        $display("timeout after %0d time units, the transfer sequence did not finish",
                 TIMEOUT);
        abort_run();
    end

    //////////////////////////////
    // test sequence
    //////////////////////////////
    initial begin
        clk            = 1'b0;
        rst_n          = 1'b0;
        load_req       = 1'b0;
        stor_req       = 1'b0;
        d_in           = '0;
        lcg_state      = 32'hacd4_d333;
        model_load_set = 1'b0;
        model_stor_set = 1'b0;

        repeat (RESET_CYCLES) @(negedge clk);
        expect_quiet();                       // values under reset
        rst_n = 1'b1;
        idle_gap();

        // round trip through set 1
        run_load(1'b0);
        idle_gap();
        run_store();
        idle_gap();
        $display("round trip finished");

        // two loads, the second with a simultaneous store request
        run_load(1'b0);
        idle_gap();
        run_load(1'b1);
        idle_gap();

        // stores return both polynomials in load order
        run_store();
        idle_gap();
        run_store();
        idle_gap();
        $display("ping-pong sequence finished");

        $display("TEST PASSED");
        $finish;
    end

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# build and run the coefficient buffer testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f src.f --top-module tb_poly_buf -o tb_poly_buf_sim

out=$(./obj_dir/tb_poly_buf_sim 2>&1) || true
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qx "TEST PASSED"; then
    exit 0
fi
exit 1

// ==== src.f ====
+incdir+src
src/poly_buf_pkg.sv
src/coef_counter.sv
src/xfer_fsm.sv
src/poly_bank_array.sv
src/poly_buf_top.sv
dv/tb_poly_buf.sv

// ==== src/coef_counter.sv ====
// coefficient index counter with last-index flag
`include "poly_buf_defs.svh"

module coef_counter (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    clear_i,  // restart at index 0
    input  logic                    run_i,    // advance one per cycle
    output poly_buf_pkg::coef_idx_t idx_o,
    output logic                    last_o
);

    poly_buf_pkg::coef_idx_t idx_q;

    //////////////////////////////
    // index register
    //////////////////////////////
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            idx_q <= '0;
        end else if (clear_i) begin
            idx_q <= '0;                                   // new transfer
        end else if (run_i) begin
            idx_q <= idx_q + poly_buf_pkg::coef_idx_t'(1); // wraps after 1023
        end
    end

    assign idx_o = idx_q;

    // final coefficient of the polynomial
    assign last_o = (idx_q == poly_buf_pkg::coef_idx_t'(`N_COEF - 1));

endmodule

// ==== src/poly_bank_array.sv ====
// two sets of eight coefficient banks with index decode and registered read
`include "poly_buf_defs.svh"

module poly_bank_array (
    input  logic                    clk,
    input  logic                    rst_n,
    input  poly_buf_pkg::bank_cmd_t cmd_i,
    input  poly_buf_pkg::coef_idx_t idx_i,
    input  poly_buf_pkg::coef_t     d_in_i,
    output poly_buf_pkg::coef_t     d_out_o,
    output logic                    d_out_valid_o
);

    poly_buf_pkg::bank_sel_t bank_sel;
    poly_buf_pkg::bank_row_t bank_row;
    logic                    bank_we [`N_SETS][`N_BANKS];
    logic                    bank_re [`N_SETS][`N_BANKS];
    poly_buf_pkg::coef_t     bank_q  [`N_SETS][`N_BANKS];
    poly_buf_pkg::set_sel_t  rd_set_q;
    poly_buf_pkg::bank_sel_t rd_bank_q;
    logic                    valid_q;

    //////////////////////////////
    // index decode
    //////////////////////////////
    // upper bits pick the bank, lower bits the row
    assign bank_sel = idx_i[`IDX_W-1 -: `BANK_W];
    assign bank_row = idx_i[`ROW_W-1:0];

    //////////////////////////////
    // bank storage
    //////////////////////////////
    for (genvar s = 0; s < `N_SETS; s++) begin : g_set
        for (genvar b = 0; b < `N_BANKS; b++) begin : g_bank
            poly_buf_pkg::coef_t mem [`BANK_DEPTH];

            // one-hot enables, only the addressed bank moves
            assign bank_we[s][b] = cmd_i.we &&
                                   (cmd_i.set_sel == poly_buf_pkg::set_sel_t'(s)) &&
                                   (bank_sel == poly_buf_pkg::bank_sel_t'(b));
            assign bank_re[s][b] = cmd_i.re &&
                                   (cmd_i.set_sel == poly_buf_pkg::set_sel_t'(s)) &&
                                   (bank_sel == poly_buf_pkg::bank_sel_t'(b));

            always_ff @(posedge clk) begin
                if (bank_we[s][b]) begin
                    mem[bank_row] <= d_in_i;
                end
            end

            // synchronous read port
            always_ff @(posedge clk) begin
                if (bank_re[s][b]) begin
                    bank_q[s][b] <= mem[bank_row];
                end
            end
        end
    end

    //////////////////////////////
    // read select and valid
    //////////////////////////////
    always_ff @(posedge clk) begin
        if (cmd_i.re) begin
            rd_set_q  <= cmd_i.set_sel;  // follows the read data
            rd_bank_q <= bank_sel;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= cmd_i.re;  // one cycle read latency
        end
    end

    assign d_out_o       = bank_q[rd_set_q][rd_bank_q];
    assign d_out_valid_o = valid_q;

endmodule

// ==== src/poly_buf_defs.svh ====
// width and count macros for the coefficient buffer
`ifndef POLY_BUF_DEFS_SVH
`define POLY_BUF_DEFS_SVH

//////////////////////////////
// coefficient geometry
//////////////////////////////
`define COEF_W      256     // bits per coefficient
`define N_COEF      1024    // coefficients per polynomial

//////////////////////////////
// bank organisation
//////////////////////////////
`define N_BANKS     8       // banks per set
`define BANK_DEPTH  128     // rows per bank
`define N_SETS      2       // ping-pong bank sets

//////////////////////////////
// index fields
//////////////////////////////
`define IDX_W       10      // full coefficient index
`define BANK_W      3       // upper index bits, bank number
`define ROW_W       7       // lower index bits, row in bank

`endif

// ==== src/poly_buf_pkg.sv ====
// coefficient, index, bank and command types plus the transfer state enum
`include "poly_buf_defs.svh"

package poly_buf_pkg;

    //////////////////////////////
    // data and address types
    //////////////////////////////
    typedef logic [`COEF_W-1:0] coef_t;     // one coefficient word
    typedef logic [`IDX_W-1:0]  coef_idx_t; // 0..1023
    typedef logic [`BANK_W-1:0] bank_sel_t; // bank inside a set
    typedef logic [`ROW_W-1:0]  bank_row_t; // row inside a bank
    typedef logic               set_sel_t;  // ping-pong set number

    //////////////////////////////
    // control types
    //////////////////////////////
    typedef enum logic [1:0] {
        IDLE  = 2'd0,
        LOAD  = 2'd1,  // streaming in from the source
        STORE = 2'd2   // streaming out to the sink
    } xfer_state_e;

    // command from the FSM to the banks
    typedef struct packed {
        logic     we;       // write the input word
        logic     re;       // read a word out
        set_sel_t set_sel;  // target bank set
    } bank_cmd_t;

endpackage

// ==== src/poly_buf_top.sv ====
// coefficient buffer top level with counter, transfer FSM and bank array
module poly_buf_top (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                load_i,         // start of a 1024-word load
    input  logic                stor_i,         // start of a 1024-word store
    input  poly_buf_pkg::coef_t d_in_i,
    output logic                load_busy_o,    // source drives a word each cycle
    output logic                load_done_o,
    output logic                stor_done_o,
    output poly_buf_pkg::coef_t d_out_o,
    output logic                d_out_valid_o
);

    logic                    cnt_clear;
    logic                    cnt_run;
    logic                    cnt_last;
    poly_buf_pkg::coef_idx_t coef_idx;
    poly_buf_pkg::bank_cmd_t bank_cmd;

    //////////////////////////////
    // coefficient index
    //////////////////////////////
    coef_counter u_coef_counter (
        .clk     (clk),
        .rst_n   (rst_n),
        .clear_i (cnt_clear),
        .run_i   (cnt_run),
        .idx_o   (coef_idx),
        .last_o  (cnt_last)
    );

    //////////////////////////////
    // transfer control
    //////////////////////////////
    xfer_fsm u_xfer_fsm (
        .clk         (clk),
        .rst_n       (rst_n),
        .load_i      (load_i),
        .stor_i      (stor_i),
        .cnt_last_i  (cnt_last),
        .cnt_clear_o (cnt_clear),
        .cnt_run_o   (cnt_run),
        .cmd_o       (bank_cmd),
        .load_done_o (load_done_o),
        .stor_done_o (stor_done_o)
    );

    // busy for exactly the write cycles
    assign load_busy_o = bank_cmd.we;

    //////////////////////////////
    // storage
    //////////////////////////////
    poly_bank_array u_poly_bank_array (
        .clk           (clk),
        .rst_n         (rst_n),
        .cmd_i         (bank_cmd),
        .idx_i         (coef_idx),
        .d_in_i        (d_in_i),
        .d_out_o       (d_out_o),
        .d_out_valid_o (d_out_valid_o)
    );

endmodule

// ==== src/xfer_fsm.sv ====
// transfer FSM with ping-pong set flags and done pulses
module xfer_fsm (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    load_i,      // load request pulse
    input  logic                    stor_i,      // store request pulse
    input  logic                    cnt_last_i,  // counter at index 1023
    output logic                    cnt_clear_o,
    output logic                    cnt_run_o,
    output poly_buf_pkg::bank_cmd_t cmd_o,
    output logic                    load_done_o,
    output logic                    stor_done_o
);

    poly_buf_pkg::xfer_state_e state_q;
    poly_buf_pkg::xfer_state_e state_d;
    logic                      load_acc;
    logic                      stor_acc;
    poly_buf_pkg::set_sel_t    load_flag_q;
    poly_buf_pkg::set_sel_t    stor_flag_q;

    //////////////////////////////
    // request acceptance
    //////////////////////////////
    // requests only count in IDLE, load has priority
    assign load_acc = (state_q == poly_buf_pkg::IDLE) && load_i;
    assign stor_acc = (state_q == poly_buf_pkg::IDLE) && stor_i && !load_i;

    always_comb begin
        state_d = state_q;
        case (state_q)
            poly_buf_pkg::IDLE: begin
                if (load_acc) begin
                    state_d = poly_buf_pkg::LOAD;
                end else if (stor_acc) begin
                    state_d = poly_buf_pkg::STORE;
                end
            end
            poly_buf_pkg::LOAD,
            poly_buf_pkg::STORE: begin
                if (cnt_last_i) begin
                    state_d = poly_buf_pkg::IDLE;  // last coefficient moved
                end
            end
            default: state_d = poly_buf_pkg::IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= poly_buf_pkg::IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    //////////////////////////////
    // ping-pong flags
    //////////////////////////////
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            load_flag_q <= 1'b0;
            stor_flag_q <= 1'b0;
        end else begin
            if (load_acc) load_flag_q <= ~load_flag_q;  // first load fills set 1
            if (stor_acc) stor_flag_q <= ~stor_flag_q;
        end
    end

    //////////////////////////////
    // counter and bank command
    //////////////////////////////
    assign cnt_clear_o = load_acc || stor_acc;
    assign cnt_run_o   = (state_q != poly_buf_pkg::IDLE);

    assign cmd_o.we      = (state_q == poly_buf_pkg::LOAD);
    assign cmd_o.re      = (state_q == poly_buf_pkg::STORE);
    assign cmd_o.set_sel = cmd_o.we ? load_flag_q : stor_flag_q;

    // done pulses, one cycle after the final index
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            load_done_o <= 1'b0;
            stor_done_o <= 1'b0;
        end else begin
            load_done_o <= (state_q == poly_buf_pkg::LOAD) && cnt_last_i;
            stor_done_o <= (state_q == poly_buf_pkg::STORE) && cnt_last_i; // with last word
        end
    end

endmodule
